// ==== conv_pkg.sv ====
package conv_pkg;

    // ################################################
    // Widths and sizes
    // ################################################

    localparam int GROUP_NB    = 4;   // Lanes per group, the adder tree is built for four
    localparam int NUM_WIDTH   = 16;  // One lane number in Q8.8
    localparam int FRAC_BITS   = 8;
    localparam int TAP_MAX     = 16;  // Deepest job the weight store can hold
    localparam int TAP_ADDR_W  = 4;
    localparam int ADD_LATENCY = 5;   // Input reg, pair sums, hold, final sum, output reg

    // ################################################
    // Types
    // ################################################

    // One signed Q8.8 lane value
    typedef logic signed [NUM_WIDTH-1:0] num_t;

    // Full product of two lane values before the shift back to Q8.8
    typedef logic signed [2*NUM_WIDTH-1:0] prod_t;

    // Four lanes side by side, lane 0 in the low bits
    typedef logic [GROUP_NB*NUM_WIDTH-1:0] lane_vec_t;

    typedef logic [TAP_ADDR_W-1:0] tap_addr_t;

    // One bit wider than the address so that a full 16-tap job fits
    typedef logic [TAP_ADDR_W:0] tap_count_t;

    typedef enum logic {
        IDLE,
        RUN
    } ctrl_state_t;

endpackage

// ==== mac_ctrl_if.sv ====
`timescale 1ns/10ps

// Per-tap control from the job controller to the weight store and the lane MACs
interface mac_ctrl_if;

    conv_pkg::tap_addr_t tap_addr;  // Index of the pixel on offer this cycle
    logic                mac_en;    // A pixel is taken this cycle
    logic                first;     // Taken pixel is tap 0
    logic                last;      // Taken pixel is the final tap of the job

    modport ctrl (
        output tap_addr,
        output mac_en,
        output first,
        output last
    );

    modport store (
        input tap_addr
    );

    modport mac (
        input mac_en,
        input first,
        input last
    );

endinterface

// ==== weight_store.sv ====
`timescale 1ns/10ps

module weight_store (
    input  logic                clk,
    input  logic                weight_wr,
    input  conv_pkg::tap_addr_t weight_addr,
    input  conv_pkg::lane_vec_t weight_data,
    mac_ctrl_if.store           ctrl_bus,
    output conv_pkg::lane_vec_t weight_lanes
);

    // One four-lane weight word per tap
    conv_pkg::lane_vec_t mem [conv_pkg::TAP_MAX];

    // ################################################
    // Write port
    // ################################################

    // Contents are kept across reset, so weights only need loading once
    always_ff @(posedge clk) begin
        if (weight_wr) begin
            mem[weight_addr] <= weight_data;
        end
    end

    // ################################################
    // Read port
    // ################################################

    // Combinational read so the weight lines up with the pixel on offer
    assign weight_lanes = mem[ctrl_bus.tap_addr];

endmodule

// ==== dot_control.sv ====
`timescale 1ns/10ps

module dot_control (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  conv_pkg::tap_count_t tap_count,
    input  logic                 pixel_valid,
    mac_ctrl_if.ctrl             ctrl_bus,
    output logic                 busy
);

    conv_pkg::ctrl_state_t state;
    conv_pkg::tap_addr_t   tap_cnt;   // Pixels taken so far in this job
    conv_pkg::tap_count_t  tap_len;   // Job length latched at start
    conv_pkg::tap_count_t  tap_final; // Index of the last tap

    logic start_ok;
    logic take;
    logic take_last;

    // ################################################
    // Per-tap decode
    // ################################################

    assign start_ok  = start && (state == conv_pkg::IDLE) && (tap_count != '0);
    assign take      = pixel_valid && (state == conv_pkg::RUN);
    assign tap_final = tap_len - conv_pkg::tap_count_t'(1);
    assign take_last = take && (conv_pkg::tap_count_t'(tap_cnt) == tap_final);

    assign ctrl_bus.tap_addr = tap_cnt;
    assign ctrl_bus.mac_en   = take;
    assign ctrl_bus.first    = take && (tap_cnt == '0);
    assign ctrl_bus.last     = take_last;

    assign busy = (state == conv_pkg::RUN);

    // ################################################
    // Job state machine
    // ################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= conv_pkg::IDLE;
            tap_cnt <= '0;
        end else begin
            case (state)
                conv_pkg::IDLE: begin
                    if (start_ok) begin
                        state   <= conv_pkg::RUN;
                        tap_cnt <= '0;
                    end
                end
                conv_pkg::RUN: begin
                    if (take_last) begin
                        state   <= conv_pkg::IDLE;  // Ready for a new start next cycle
                        tap_cnt <= '0;
                    end else if (take) begin
                        tap_cnt <= tap_cnt + conv_pkg::tap_addr_t'(1);
                    end
                end
                default: begin
                    state <= conv_pkg::IDLE;
                end
            endcase
        end
    end

    // Length is only read while in RUN, which always follows a latch here
    always_ff @(posedge clk) begin
        if (start_ok) begin
            tap_len <= tap_count;
        end
    end

endmodule

// ==== group_mac.sv ====
`timescale 1ns/10ps

module group_mac (
    input  logic                clk,
    input  logic                reset,
    mac_ctrl_if.mac             ctrl_bus,
    input  conv_pkg::lane_vec_t pixel_data,
    input  conv_pkg::lane_vec_t weight_lanes,
    output conv_pkg::lane_vec_t lane_sum,
    output logic                sum_valid
);

    conv_pkg::num_t  pix_lane  [conv_pkg::GROUP_NB];
    conv_pkg::num_t  wgt_lane  [conv_pkg::GROUP_NB];
    conv_pkg::prod_t prod_q    [conv_pkg::GROUP_NB];  // Full products of the taken pixel
    conv_pkg::num_t  lane_term [conv_pkg::GROUP_NB];  // Product back in Q8.8
    conv_pkg::num_t  acc_q     [conv_pkg::GROUP_NB];

    logic en_q;
    logic first_q;
    logic last_q;

    // Split the packed buses into lanes and pack the totals back
    always_comb begin
        for (int i = 0; i < conv_pkg::GROUP_NB; i++) begin
            pix_lane[i] = pixel_data[i*conv_pkg::NUM_WIDTH +: conv_pkg::NUM_WIDTH];
            wgt_lane[i] = weight_lanes[i*conv_pkg::NUM_WIDTH +: conv_pkg::NUM_WIDTH];
            // Arithmetic shift keeps the sign and the cast keeps the low 16 bits
            lane_term[i] = conv_pkg::num_t'(prod_q[i] >>> conv_pkg::FRAC_BITS);
            lane_sum[i*conv_pkg::NUM_WIDTH +: conv_pkg::NUM_WIDTH] = acc_q[i];
        end
    end

    // ################################################
    // Multiply stage
    // ################################################

    always_ff @(posedge clk) begin
        for (int i = 0; i < conv_pkg::GROUP_NB; i++) begin
            // Signed 16x16 into 32 bits
            prod_q[i] <= conv_pkg::prod_t'(pix_lane[i]) * conv_pkg::prod_t'(wgt_lane[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            en_q    <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            en_q    <= ctrl_bus.mac_en;
            first_q <= ctrl_bus.mac_en && ctrl_bus.first;
            last_q  <= ctrl_bus.mac_en && ctrl_bus.last;
        end
    end

    // ################################################
    // Accumulate stage
    // ################################################

    // First tap loads so a new job can follow the previous last tap directly
    always_ff @(posedge clk) begin
        for (int i = 0; i < conv_pkg::GROUP_NB; i++) begin
            if (en_q) begin
                acc_q[i] <= first_q ? lane_term[i] : acc_q[i] + lane_term[i];
            end
        end
    end

    // Totals are final in the cycle after the last tap is added
    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= en_q && last_q;
        end
    end

endmodule

// ==== group_add.sv ====
`timescale 1ns/10ps

module group_add (
    input  logic                clk,
    input  logic                reset,
    input  conv_pkg::lane_vec_t up_data,
    input  logic                up_valid,
    output conv_pkg::num_t      dn_data,
    output logic                dn_valid
);

    conv_pkg::lane_vec_t up_data_r;
    conv_pkg::num_t      pair_sum  [2];  // Lanes 0+1 and 2+3
    conv_pkg::num_t      pair_hold [2];
    conv_pkg::num_t      total;

    logic [conv_pkg::ADD_LATENCY-1:0] valid_sr;

    // Signed add that wraps at the lane width
    function automatic conv_pkg::num_t add_wrap(conv_pkg::num_t a, conv_pkg::num_t b);
        return a + b;
    endfunction

    // ################################################
    // Adder tree
    // ################################################

    always_ff @(posedge clk) begin
        up_data_r <= up_data;

        pair_sum[0] <= add_wrap(up_data_r[0*conv_pkg::NUM_WIDTH +: conv_pkg::NUM_WIDTH],
                                up_data_r[1*conv_pkg::NUM_WIDTH +: conv_pkg::NUM_WIDTH]);
        pair_sum[1] <= add_wrap(up_data_r[2*conv_pkg::NUM_WIDTH +: conv_pkg::NUM_WIDTH],
                                up_data_r[3*conv_pkg::NUM_WIDTH +: conv_pkg::NUM_WIDTH]);

        pair_hold[0] <= pair_sum[0];  // Extra stage to give the final add a full cycle
        pair_hold[1] <= pair_sum[1];

        total   <= add_wrap(pair_hold[0], pair_hold[1]);
        dn_data <= total;
    end

    // ################################################
    // Valid line
    // ################################################

    // Same depth as the data path so the strobe lands on its sum
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[conv_pkg::ADD_LATENCY-2:0], up_valid};
        end
    end

    assign dn_valid = valid_sr[conv_pkg::ADD_LATENCY-1];

endmodule

// ==== conv_dot.sv ====
`timescale 1ns/10ps

module conv_dot (
    input  logic                 clk,
    input  logic                 reset,

    // Weight load port
    input  logic                 weight_wr,
    input  conv_pkg::tap_addr_t  weight_addr,
    input  conv_pkg::lane_vec_t  weight_data,

    // Job control and pixel stream
    input  logic                 start,
    input  conv_pkg::tap_count_t tap_count,
    input  logic                 pixel_valid,
    input  conv_pkg::lane_vec_t  pixel_data,

    output logic                 busy,
    output logic                 result_valid,
    output conv_pkg::num_t       result_data
);

    conv_pkg::lane_vec_t weight_lanes;
    conv_pkg::lane_vec_t lane_sum;
    logic                sum_valid;

    mac_ctrl_if mac_ctrl ();

    dot_control dot_control_inst (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .tap_count   (tap_count),
        .pixel_valid (pixel_valid),
        .ctrl_bus    (mac_ctrl.ctrl),
        .busy        (busy)
    );

    weight_store weight_store_inst (
        .clk          (clk),
        .weight_wr    (weight_wr),
        .weight_addr  (weight_addr),
        .weight_data  (weight_data),
        .ctrl_bus     (mac_ctrl.store),
        .weight_lanes (weight_lanes)
    );

    group_mac group_mac_inst (
        .clk          (clk),
        .reset        (reset),
        .ctrl_bus     (mac_ctrl.mac),
        .pixel_data   (pixel_data),
        .weight_lanes (weight_lanes),
        .lane_sum     (lane_sum),
        .sum_valid    (sum_valid)
    );

    group_add group_add_inst (
        .clk      (clk),
        .reset    (reset),
        .up_data  (lane_sum),
        .up_valid (sum_valid),
        .dn_data  (result_data),
        .dn_valid (result_valid)
    );

endmodule

// ==== tb_conv_dot.sv ====
`timescale 1ns/10ps

module tb_conv_dot;

    localparam int CLK_PERIOD   = 20;
    localparam int RESULT_DELAY = 7;   // Edges from the last pixel edge to result_valid
    localparam int RAND_JOBS    = 12;
    localparam int GAP_JOBS     = 4;
    localparam int B2B_JOBS     = 6;
    localparam int STRAY_JOBS   = 2;
    localparam int JOB_TOTAL    = 1 + RAND_JOBS + GAP_JOBS + B2B_JOBS + STRAY_JOBS;
    // Gap jobs spend up to four cycles on each pixel
    localparam int PIXEL_TOTAL  = 4 + (RAND_JOBS + B2B_JOBS + STRAY_JOBS) * conv_pkg::TAP_MAX
                                  + GAP_JOBS * conv_pkg::TAP_MAX * 4;
    localparam int WATCHDOG_NS  = (PIXEL_TOTAL + 50 * JOB_TOTAL) * CLK_PERIOD;

    logic                 clk;
    logic                 reset;
    logic                 weight_wr;
    conv_pkg::tap_addr_t  weight_addr;
    conv_pkg::lane_vec_t  weight_data;
    logic                 start;
    conv_pkg::tap_count_t tap_count;
    logic                 pixel_valid;
    conv_pkg::lane_vec_t  pixel_data;
    logic                 busy;
    logic                 result_valid;
    conv_pkg::num_t       result_data;

    conv_pkg::lane_vec_t wmem    [conv_pkg::TAP_MAX];  // Mirror of the weight store
    conv_pkg::lane_vec_t pix_buf [conv_pkg::TAP_MAX];  // Pixels of the job being driven
    conv_pkg::num_t      exp_data [$];
    int                  exp_due  [$];                 // Cycle at which each result is due

    int             head_idx = 0;
    logic           head_avail = 1'b0;
    conv_pkg::num_t head_data = '0;
    int             head_due = 0;
    int             cycle = 0;
    logic           exp_busy = 1'b0;
    int             seed = 32'h97f8949e;
    int             err_value = 0;
    int             err_time = 0;
    int             err_busy = 0;
    int             err_mark = 0;
    int             tests_passed = 0;
    int             tests_failed = 0;

    conv_dot conv_dot_inst (
        .clk          (clk),
        .reset        (reset),
        .weight_wr    (weight_wr),
        .weight_addr  (weight_addr),
        .weight_data  (weight_data),
        .start        (start),
        .tap_count    (tap_count),
        .pixel_valid  (pixel_valid),
        .pixel_data   (pixel_data),
        .busy         (busy),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Step past each result and show the next expected one to the checks
    always @(posedge clk) begin
        if (result_valid) begin
            head_idx = head_idx + 1;
        end
        head_avail = head_idx < exp_data.size();
        if (head_avail) begin
            head_data = exp_data[head_idx];
            head_due  = exp_due[head_idx];
        end
    end

    // ##################################################
    // Checks
    // ##################################################

    result_value_check: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (head_avail && result_data == head_data))
    else begin
        $display("ERR %0t: result %h, expected %h (expected one pending: %b)", $time,
                 $sampled(result_data), $sampled(head_data), $sampled(head_avail));
        err_value++;
    end

    result_time_check: assert property (@(posedge clk) disable iff (reset)
        (result_valid && head_avail) |-> cycle == head_due)
    else begin
        $display("ERR %0t: result came in cycle %0d, due in cycle %0d", $time,
                 $sampled(cycle), $sampled(head_due));
        err_time++;
    end

    // Checked on the falling edge, after busy has settled from the rising edge
    busy_check: assert property (@(negedge clk) disable iff (reset) busy == exp_busy)
    else begin
        $display("ERR %0t: busy is %b, expected %b", $time, $sampled(busy), $sampled(exp_busy));
        err_busy++;
    end

    // ##################################################
    // Model and stimulus
    // ##################################################

    function automatic conv_pkg::lane_vec_t random_lanes();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int random_taps();
        return int'($unsigned($random(seed)) % conv_pkg::TAP_MAX) + 1;
    endfunction

    // Q8.8 product with the fraction dropped, lane sums and final sum wrap at 16 bits
    function automatic conv_pkg::num_t expected_dot(input int taps);
        conv_pkg::num_t     lane_acc [conv_pkg::GROUP_NB];
        conv_pkg::num_t     px;
        conv_pkg::num_t     wt;
        logic signed [31:0] prod;
        conv_pkg::num_t     total;
        total = '0;
        for (int l = 0; l < conv_pkg::GROUP_NB; l++) begin
            lane_acc[l] = '0;
            for (int t = 0; t < taps; t++) begin
                px   = pix_buf[t][l*16 +: 16];
                wt   = wmem[t][l*16 +: 16];
                prod = {{16{px[15]}}, px} * {{16{wt[15]}}, wt};
                lane_acc[l] = lane_acc[l] + prod[23:8];
            end
            total = total + lane_acc[l];
        end
        return total;
    endfunction

    task automatic write_weight(input int addr, input conv_pkg::lane_vec_t data);
        weight_wr   = 1'b1;
        weight_addr = conv_pkg::tap_addr_t'(addr);
        weight_data = data;
        wmem[addr]  = data;
        @(negedge clk);
        weight_wr = 1'b0;
    endtask

    task automatic fill_pixels(input int taps);
        for (int i = 0; i < taps; i++) pix_buf[i] = random_lanes();
    endtask

    // Starts a job and streams pix_buf, with random idle gaps and an optional ignored start
    task automatic run_job(input int taps, input int max_gap, input bit stray);
        int gap;
        start     = 1'b1;
        tap_count = conv_pkg::tap_count_t'(taps);
        pixel_valid = 1'b0;
        exp_busy  = 1'b1;
        @(negedge clk);
        for (int i = 0; i < taps; i++) begin
            start = 1'b0;
            gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
            repeat (gap) begin
                pixel_valid = 1'b0;
                pixel_data  = random_lanes();
                @(negedge clk);
            end
            pixel_valid = 1'b1;
            pixel_data  = pix_buf[i];
            start       = stray && (i == taps / 2);
            tap_count   = stray ? conv_pkg::tap_count_t'(random_taps()) : tap_count;
            if (i == taps - 1) begin
                exp_data.push_back(expected_dot(taps));
                exp_due.push_back(cycle + RESULT_DELAY);
                exp_busy = 1'b0;
            end
            @(negedge clk);
        end
        pixel_valid = 1'b0;
        start       = 1'b0;
    endtask

    task automatic wait_results();
        while (head_idx < exp_data.size()) @(negedge clk);
        repeat (2) @(negedge clk);  // Room for a stray extra result to show up
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_value + err_time + err_busy;
        if (errs == err_mark) begin
            tests_passed++;
            $display("Test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, errs - err_mark);
        end
        err_mark = errs;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int taps;
        reset       = 1'b1;
        weight_wr   = 1'b0;
        weight_addr = '0;
        weight_data = '0;
        start       = 1'b0;
        tap_count   = '0;
        pixel_valid = 1'b0;
        pixel_data  = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        repeat (20) @(negedge clk);  // Idle, nothing may come out
        end_test("reset_idle");

        write_weight(0, {16'h8000, 16'h0040, 16'hff00, 16'h0180});
        write_weight(1, {16'h0123, 16'hfe00, 16'h7fff, 16'h0080});
        write_weight(2, {16'hffff, 16'h0300, 16'h00c0, 16'hfc40});
        write_weight(3, {16'h0100, 16'h8001, 16'h0055, 16'hff80});
        pix_buf[0] = {16'h0100, 16'h0280, 16'hfe80, 16'h00c3};
        pix_buf[1] = {16'hff01, 16'h0033, 16'h7fff, 16'h0200};
        pix_buf[2] = {16'h0001, 16'hfffd, 16'h0155, 16'h8000};
        pix_buf[3] = {16'h4000, 16'h0100, 16'hff7f, 16'h0011};
        run_job(4, 0, 1'b0);
        wait_results();
        end_test("hand_4tap");

        for (int a = 0; a < conv_pkg::TAP_MAX; a++) write_weight(a, random_lanes());
        repeat (RAND_JOBS) begin
            taps = random_taps();
            fill_pixels(taps);
            run_job(taps, 0, 1'b0);
            repeat (2) @(negedge clk);
        end
        wait_results();
        end_test("random_jobs");

        repeat (GAP_JOBS) begin
            // Pixels offered while idle must be dropped
            repeat (3) begin
                pixel_valid = 1'b1;
                pixel_data  = random_lanes();
                @(negedge clk);
            end
            taps = random_taps();
            fill_pixels(taps);
            run_job(taps, 3, 1'b0);
        end
        wait_results();
        end_test("pixel_gaps");

        repeat (B2B_JOBS) begin
            taps = random_taps();
            fill_pixels(taps);
            run_job(taps, 0, 1'b0);
        end
        wait_results();
        end_test("back_to_back");

        start     = 1'b1;  // Zero length start while idle
        tap_count = '0;
        @(negedge clk);
        start = 1'b0;
        repeat (10) @(negedge clk);
        repeat (STRAY_JOBS) begin
            taps = random_taps();
            fill_pixels(taps);
            run_job(taps, 0, 1'b1);
        end
        wait_results();
        end_test("ignored_starts");

        $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, err_value + err_time + err_busy);
        if (tests_failed == 0 && err_value + err_time + err_busy == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== conv_dot.f ====
conv_pkg.sv
mac_ctrl_if.sv
weight_store.sv
dot_control.sv
group_mac.sv
group_add.sv
conv_dot.sv
tb_conv_dot.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_conv_dot -f conv_dot.f -o sim_conv_dot
./obj_dir/sim_conv_dot | tee sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi
